// File: all.f
hw/soc_pkg.sv
hw/word_fifo.sv
hw/word_ram.sv
hw/boot_counter.sv
hw/spi_cmd_fsm.sv
hw/bus_port.sv
hw/soc_top.sv
tb/tb_clock.sv
tb/tb_soc.sv

// File: hw/boot_counter.sv
// bootload word address and remaining word count, also placed directly for debug reads
`timescale 1ns/100ps

module boot_counter import soc_pkg::*; (
   input  logic  clk100mhz,
   input  logic  cpu_reset,
   input  logic  load,
   input  word_t load_count,
   input  logic  step,
   input  logic  set_addr,
   input  word_t new_addr,
   output word_t boot_addr,
   output word_t words_left
);

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         boot_addr  <= '0;
         words_left <= '0;
      end else if (load) begin
         boot_addr  <= '0;           // images always start at word 0
         words_left <= load_count;
      end else if (set_addr) begin
         boot_addr <= new_addr;
      end else if (step) begin
         boot_addr  <= boot_addr + 1'b1;
         words_left <= words_left - 1'b1;
      end
   end

endmodule

// File: hw/bus_port.sv
// processor bus decoder, RAM arbiter between boot path and processor, and interrupt raiser
`timescale 1ns/100ps

module bus_port import soc_pkg::*; (
   input  logic                  clk100mhz,
   input  logic                  cpu_reset,
   input  logic                  bus_rd,
   input  logic                  bus_wr,
   input  word_t                 bus_addr,
   input  word_t                 bus_wdata,
   output word_t                 bus_rdata,
   output logic                  bus_rdata_ready,
   output logic                  bus_wr_ack,
   input  logic                  irq_ack,
   input  logic                  irq_busy,
   output logic                  irq,
   output logic [4:0]            irq_num,
   output logic                  cpu_stall,
   input  logic                  boot_mode,
   input  logic                  boot_wr,
   input  logic                  boot_rd,
   input  word_t                 boot_wdata,
   input  word_t                 boot_addr,
   output logic                  ram_en,
   output logic                  ram_wr,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output word_t                 ram_wdata,
   input  logic                  ram_ready,
   input  logic                  ram_rd_valid,
   input  word_t                 ram_rdata,
   output logic                  in_rd,
   input  word_t                 in_rdata,
   input  logic                  in_empty,
   output logic                  out_wr,
   output word_t                 out_wdata,
   input  logic                  out_full
);

   logic [1:0] state;
   logic       is_mem;
   word_t      mem_off;
   logic       trap;        // unmapped read waiting for its interrupt

   assign is_mem    = (bus_addr >= MEM_BASE);
   assign mem_off   = bus_addr - MEM_BASE;
   assign cpu_stall = boot_mode;

   assign in_rd     = (state == BUS_IDLE) && !boot_mode && bus_rd
                      && (bus_addr == REG_IN_DATA) && !in_empty;
   assign out_wr    = (state == BUS_WRITE) && (bus_addr == REG_OUT_DATA) && !out_full;
   assign out_wdata = bus_wdata;

   // boot path owns the RAM while the processor is stalled
   always_comb begin
      if (boot_mode) begin
         ram_en    = boot_wr || boot_rd;
         ram_wr    = boot_wr;
         ram_addr  = boot_addr[RAM_ADDR_W-1:0];
         ram_wdata = boot_wdata;
      end else begin
         ram_en    = is_mem && ((state == BUS_READ) || (state == BUS_WRITE));
         ram_wr    = (state == BUS_WRITE);
         ram_addr  = mem_off[RAM_ADDR_W-1:0];
         ram_wdata = bus_wdata;
      end
   end

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         state           <= BUS_IDLE;
         bus_rdata_ready <= 1'b0;
         bus_wr_ack      <= 1'b0;
         trap            <= 1'b0;
         irq             <= 1'b0;
         irq_num         <= IRQ_MAILBOX;
      end else begin
         case (state)
            BUS_IDLE: begin
               if (!boot_mode && bus_rd) begin
                  if (is_mem || in_rd) begin
                     state <= BUS_READ;
                  end else if (bus_addr == REG_IN_STATUS) begin
                     bus_rdata       <= {31'b0, !in_empty};
                     bus_rdata_ready <= 1'b1;
                     state           <= BUS_WAIT;
                  end else if (bus_addr == REG_OUT_STATUS) begin
                     bus_rdata       <= {31'b0, !out_full};
                     bus_rdata_ready <= 1'b1;
                     state           <= BUS_WAIT;
                  end else if (bus_addr != REG_IN_DATA) begin
                     bus_rdata       <= '0;        // unmapped
                     bus_rdata_ready <= 1'b1;
                     trap            <= 1'b1;
                     state           <= BUS_WAIT;
                  end                              // empty inbound mailbox, retry
               end else if (!boot_mode && bus_wr) begin
                  state <= BUS_WRITE;
               end
            end
            BUS_READ: begin
               if (!is_mem || ram_rd_valid) begin
                  bus_rdata       <= is_mem ? ram_rdata : in_rdata;
                  bus_rdata_ready <= 1'b1;
                  state           <= BUS_WAIT;
               end
            end
            BUS_WRITE: begin
               // other writes are acked and dropped
               if (is_mem ? ram_ready : (out_wr || bus_addr != REG_OUT_DATA)) begin
                  bus_wr_ack <= 1'b1;
                  state      <= BUS_WAIT;
               end
            end
            default: begin
               if (!bus_rd && !bus_wr) begin
                  bus_rdata_ready <= 1'b0;
                  bus_wr_ack      <= 1'b0;
                  state           <= BUS_IDLE;
               end
            end
         endcase

         if (irq_ack) begin
            irq <= 1'b0;
         end else if (!in_empty && !irq_busy) begin
            irq     <= 1'b1;
            irq_num <= IRQ_MAILBOX;
         end else if (trap) begin
            irq     <= 1'b1;
            irq_num <= IRQ_TRAP;
            trap    <= 1'b0;
         end
      end
   end

endmodule

// File: hw/soc_pkg.sv
// shared types, address map, command codes and state encodings, imported by every controller block
package soc_pkg;

   typedef logic [31:0] word_t;

   // one link word, a command in idle and plain data in every other state
   typedef union packed {
      word_t raw;
      struct packed {
         logic [15:0] arg;
         logic [15:0] code;
      } cmd;
   } link_word_t;

   localparam int RAM_WORDS  = 4096;
   localparam int RAM_ADDR_W = 12;
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = 4;       // log2 of FIFO_DEPTH

   // processor bus map
   localparam word_t MEM_BASE       = 32'h0002_0000;
   localparam word_t REG_IN_DATA    = 32'h0001_0001;
   localparam word_t REG_IN_STATUS  = 32'h0001_0002;
   localparam word_t REG_OUT_DATA   = 32'h0001_0004;
   localparam word_t REG_OUT_STATUS = 32'h0001_0005;

   // link command codes
   localparam logic [15:0] CMD_BOOTLOAD = 16'd99;
   localparam logic [15:0] CMD_POLL     = 16'd1;
   localparam logic [15:0] CMD_SEND     = 16'd2;
   localparam logic [15:0] CMD_RESTART  = 16'd3;
   localparam logic [15:0] CMD_DEBUGMEM = 16'd8;

   localparam word_t       EMPTY_REPLY = 32'hffff_ffff;
   localparam logic [15:0] DEAD_TAG    = 16'hdead;

   localparam logic [4:0] IRQ_MAILBOX = 5'd0;
   localparam logic [4:0] IRQ_TRAP    = 5'd6;

   // command controller states
   localparam logic [3:0] SPI_IDLE       = 4'd0;
   localparam logic [3:0] SPI_BOOT_START = 4'd1;   // waiting for the word count
   localparam logic [3:0] SPI_BOOT_NEXT  = 4'd2;
   localparam logic [3:0] SPI_BOOT_RD    = 4'd3;   // read-back of the word just written
   localparam logic [3:0] SPI_POLL       = 4'd4;
   localparam logic [3:0] SPI_POLL_RD    = 4'd5;
   localparam logic [3:0] SPI_SEND       = 4'd6;
   localparam logic [3:0] SPI_GET_ADDR   = 4'd7;
   localparam logic [3:0] SPI_DBG_RD     = 4'd8;
   localparam logic [3:0] SPI_DEAD       = 4'd9;

   // bus port states
   localparam logic [1:0] BUS_IDLE  = 2'd0;
   localparam logic [1:0] BUS_READ  = 2'd1;
   localparam logic [1:0] BUS_WRITE = 2'd2;
   localparam logic [1:0] BUS_WAIT  = 2'd3;   // until the processor drops its strobe

endpackage

// File: hw/soc_top.sv
// system controller top, link and processor bus on one side, program RAM and mailboxes inside
`timescale 1ns/100ps

module soc_top import soc_pkg::*; (
   input  logic       clk100mhz,
   input  logic       cpu_reset,
   input  link_word_t link_word,
   input  logic       link_word_new,
   input  logic       reply_taken,
   output word_t      reply_word,
   output logic       reply_valid,
   input  logic       bus_rd,
   input  logic       bus_wr,
   input  word_t      bus_addr,
   input  word_t      bus_wdata,
   output word_t      bus_rdata,
   output logic       bus_rdata_ready,
   output logic       bus_wr_ack,
   input  logic       irq_ack,
   input  logic       irq_busy,
   output logic       irq,
   output logic [4:0] irq_num,
   output logic       cpu_stall,
   output logic       cpu_restart,
   output logic [1:0] led
);

   logic                  boot_mode, boot_wr, boot_rd;
   word_t                 boot_wdata, boot_addr, words_left;
   logic                  cnt_load, cnt_step, cnt_set_addr;
   logic                  ram_en, ram_wr, ram_ready, ram_rd_valid;
   logic [RAM_ADDR_W-1:0] ram_addr;
   word_t                 ram_wdata, ram_rdata;
   logic                  in_wr, in_rd, in_full, in_empty;
   word_t                 in_wdata, in_rdata;
   logic                  out_wr, out_rd, out_full, out_empty;
   word_t                 out_wdata, out_rdata;

   spi_cmd_fsm i_spi_cmd_fsm (
      .clk100mhz, .cpu_reset, .link_word, .link_word_new, .reply_taken,
      .reply_word, .reply_valid, .boot_mode, .boot_wr, .boot_rd, .boot_wdata,
      .ram_ready, .ram_rd_valid, .ram_rdata, .cnt_load, .cnt_step, .cnt_set_addr,
      .words_left, .in_wr, .in_wdata, .in_full, .out_rd, .out_rdata, .out_empty,
      .cpu_restart, .led
   );

   boot_counter i_boot_counter (
      .clk100mhz, .cpu_reset, .load(cnt_load), .load_count(link_word.raw),
      .step(cnt_step), .set_addr(cnt_set_addr), .new_addr(link_word.raw),
      .boot_addr, .words_left
   );

   // link to processor
   word_fifo mbox_in (
      .clk100mhz, .cpu_reset, .wr_data(in_wdata), .wr_en(in_wr), .rd_en(in_rd),
      .rd_data(in_rdata), .full(in_full), .empty(in_empty)
   );

   // processor to link
   word_fifo mbox_out (
      .clk100mhz, .cpu_reset, .wr_data(out_wdata), .wr_en(out_wr), .rd_en(out_rd),
      .rd_data(out_rdata), .full(out_full), .empty(out_empty)
   );

   word_ram i_word_ram (
      .clk100mhz, .cpu_reset, .cmd_en(ram_en), .cmd_wr(ram_wr), .cmd_addr(ram_addr),
      .cmd_wdata(ram_wdata), .ram_rdata, .ram_ready, .ram_rd_valid
   );

   bus_port i_bus_port (
      .clk100mhz, .cpu_reset, .bus_rd, .bus_wr, .bus_addr, .bus_wdata, .bus_rdata,
      .bus_rdata_ready, .bus_wr_ack, .irq_ack, .irq_busy, .irq, .irq_num, .cpu_stall,
      .boot_mode, .boot_wr, .boot_rd, .boot_wdata, .boot_addr, .ram_en, .ram_wr,
      .ram_addr, .ram_wdata, .ram_ready, .ram_rd_valid, .ram_rdata, .in_rd, .in_rdata,
      .in_empty, .out_wr, .out_wdata, .out_full
   );

endmodule

// File: hw/spi_cmd_fsm.sv
// link command controller, runs bootload with read-back, mailbox traffic, restart and debug reads
`timescale 1ns/100ps

module spi_cmd_fsm import soc_pkg::*; (
   input  logic       clk100mhz,
   input  logic       cpu_reset,
   input  link_word_t link_word,
   input  logic       link_word_new,
   input  logic       reply_taken,
   output word_t      reply_word,
   output logic       reply_valid,
   output logic       boot_mode,
   output logic       boot_wr,
   output logic       boot_rd,
   output word_t      boot_wdata,
   input  logic       ram_ready,
   input  logic       ram_rd_valid,
   input  word_t      ram_rdata,
   output logic       cnt_load,
   output logic       cnt_step,
   output logic       cnt_set_addr,
   input  word_t      words_left,
   output logic       in_wr,
   output word_t      in_wdata,
   input  logic       in_full,
   output logic       out_rd,
   input  word_t      out_rdata,
   input  logic       out_empty,
   output logic       cpu_restart,
   output logic [1:0] led
);

   logic [3:0]  state;
   logic        poll_hit;     // outbound mailbox had a word when polled
   logic [15:0] boot_total;
   word_t       dead_word;

   // RAM requests go out in the same cycle as the link strobe
   assign boot_wdata = link_word.raw;
   assign boot_wr    = (state == SPI_BOOT_NEXT) && link_word_new && ram_ready;
   assign boot_rd    = ((state == SPI_BOOT_RD) || (state == SPI_DBG_RD)) && ram_ready;

   assign cnt_load     = (state == SPI_BOOT_START) && link_word_new;
   assign cnt_set_addr = (state == SPI_GET_ADDR) && link_word_new;
   assign cnt_step     = (state == SPI_BOOT_RD) && ram_rd_valid;

   assign in_wdata = link_word.raw;
   assign in_wr    = (state == SPI_SEND) && link_word_new && !in_full;
   assign out_rd   = (state == SPI_POLL) && !out_empty;

   // address of the word that overran, from the count at load
   assign dead_word = {DEAD_TAG, boot_total - words_left[15:0]};

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         state       <= SPI_IDLE;
         boot_mode   <= 1'b1;        // processor held until a program is in
         reply_valid <= 1'b0;
         cpu_restart <= 1'b0;
         led         <= 2'b00;
         poll_hit    <= 1'b0;
      end else begin
         cpu_restart <= 1'b0;
         if (reply_taken)
            reply_valid <= 1'b0;
         case (state)
            SPI_IDLE: begin
               if (link_word_new) begin
                  case (link_word.cmd.code)
                     CMD_BOOTLOAD: state <= SPI_BOOT_START;
                     CMD_POLL:     state <= SPI_POLL;
                     CMD_SEND:     state <= SPI_SEND;
                     CMD_RESTART:  cpu_restart <= 1'b1;
                     CMD_DEBUGMEM: state <= SPI_GET_ADDR;
                     default:      state <= SPI_IDLE;   // unknown codes dropped
                  endcase
               end
            end
            SPI_BOOT_START: begin
               if (link_word_new) begin
                  boot_total <= link_word.raw[15:0];
                  boot_mode  <= 1'b1;
                  state      <= SPI_BOOT_NEXT;
               end
            end
            SPI_BOOT_NEXT: begin
               if (link_word_new && ram_ready) begin
                  state <= SPI_BOOT_RD;
               end else if (link_word_new) begin
                  reply_word  <= dead_word;
                  reply_valid <= 1'b1;
                  state       <= SPI_DEAD;
               end
            end
            SPI_BOOT_RD: begin
               if (link_word_new) begin        // next word came before verification
                  reply_word  <= dead_word;
                  reply_valid <= 1'b1;
                  state       <= SPI_DEAD;
               end else if (ram_rd_valid) begin
                  reply_word  <= ram_rdata;    // echo of what the RAM holds
                  reply_valid <= 1'b1;
                  if (words_left > 32'd1) begin
                     state <= SPI_BOOT_NEXT;
                  end else begin
                     boot_mode   <= 1'b0;
                     cpu_restart <= 1'b1;
                     led         <= 2'b11;     // program loaded
                     state       <= SPI_IDLE;
                  end
               end
            end
            SPI_POLL: begin
               poll_hit <= !out_empty;
               state    <= SPI_POLL_RD;
            end
            SPI_POLL_RD: begin
               reply_word  <= poll_hit ? out_rdata : EMPTY_REPLY;
               reply_valid <= 1'b1;
               state       <= SPI_IDLE;
            end
            SPI_SEND: begin
               if (link_word_new)
                  state <= SPI_IDLE;
            end
            SPI_GET_ADDR: begin
               if (link_word_new) begin
                  boot_mode <= 1'b1;           // borrow the boot path for one read
                  state     <= SPI_DBG_RD;
               end
            end
            SPI_DBG_RD: begin
               if (ram_rd_valid) begin
                  reply_word  <= ram_rdata;
                  reply_valid <= 1'b1;
                  boot_mode   <= 1'b0;
                  state       <= SPI_IDLE;
               end
            end
            SPI_DEAD: led <= 2'b10;            // stuck here until reset
            default:  state <= SPI_IDLE;
         endcase
      end
   end

   a_reply_held: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      reply_valid && !reply_taken |=> $stable(reply_word));

endmodule

// File: hw/word_fifo.sv
// word mailbox FIFO between the link controller and the processor, one instance per direction
`timescale 1ns/100ps

module word_fifo import soc_pkg::*; (
   input  logic  clk100mhz,
   input  logic  cpu_reset,
   input  word_t wr_data,
   input  logic  wr_en,
   input  logic  rd_en,
   output word_t rd_data,
   output logic  full,
   output logic  empty
);

   word_t                 mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   assign full  = (count == FIFO_DEPTH);
   assign empty = (count == 0);
   assign do_wr = wr_en && !full;   // a write to a full mailbox is lost
   assign do_rd = rd_en && !empty;

   always_ff @(posedge clk100mhz) begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
      if (do_rd)
         rd_data <= mem[rd_ptr];     // held until the next read
   end

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + do_wr - do_rd;
      end
   end

   a_no_overflow: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      wr_en |-> !full);
   a_no_underflow: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      rd_en |-> !empty);

endmodule

// File: hw/word_ram.sv
// single-port program RAM, shared by the bootloader and the processor through the bus port
`timescale 1ns/100ps

module word_ram import soc_pkg::*; (
   input  logic                  clk100mhz,
   input  logic                  cpu_reset,
   input  logic                  cmd_en,
   input  logic                  cmd_wr,
   input  logic [RAM_ADDR_W-1:0] cmd_addr,
   input  word_t                 cmd_wdata,
   output word_t                 ram_rdata,
   output logic                  ram_ready,
   output logic                  ram_rd_valid
);

   word_t mem [RAM_WORDS];
   logic  take;

   assign take = cmd_en && ram_ready;

   always_ff @(posedge clk100mhz) begin
      if (take && cmd_wr)
         mem[cmd_addr] <= cmd_wdata;
      else if (take)
         ram_rdata <= mem[cmd_addr];
   end

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         ram_ready    <= 1'b1;
         ram_rd_valid <= 1'b0;
      end else begin
         ram_ready    <= !take;          // busy for one cycle per command
         ram_rd_valid <= take && !cmd_wr;
      end
   end

   // a command needs a defined direction and address
   a_known_cmd: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      cmd_en |-> !$isunknown({cmd_wr, cmd_addr}));

endmodule

// File: tb/tb_clock.sv
// testbench clock and reset source, 100 MHz clock with reset held low for the first 4 cycles
`timescale 1ns/100ps

module tb_clock (
   output logic clk100mhz,
   output logic cpu_reset
);

   initial begin
      clk100mhz = 1'b0;
      forever #5 clk100mhz = ~clk100mhz;   // 10 ns period
   end

   initial begin
      cpu_reset = 1'b0;
      repeat (4) @(posedge clk100mhz);
      #1 cpu_reset = 1'b1;                 // released like any other input
   end

endmodule

// File: tb/tb_soc.sv
// testbench for the system controller, drives link and bus, checks with concurrent assertions
`timescale 1ns/100ps

module tb_soc import soc_pkg::*; ();

   // whole sequence needs a few hundred cycles, so this leaves a wide margin
   localparam int MAX_CYCLES = 4000;
   localparam int BOOT_WORDS = 8;

   logic       clk100mhz, cpu_reset;
   link_word_t link_word;
   logic       link_word_new, reply_taken, reply_valid;
   word_t      reply_word;
   logic       bus_rd, bus_wr, bus_rdata_ready, bus_wr_ack;
   word_t      bus_addr, bus_wdata, bus_rdata;
   logic       irq_ack, irq_busy, irq, cpu_stall, cpu_restart;
   logic [4:0] irq_num;
   logic [1:0] led;

   // reference model
   word_t      boot_words[$];
   word_t      in_q[$];
   word_t      out_q[$];
   word_t      exp_reply, exp_rdata;
   logic [4:0] exp_irq_num;
   logic       is_cmd, boot_data, last_word;
   int         seed = 32'h7695;
   int         errors, replies, reads, cycles;

   tb_clock i_tb_clock (.clk100mhz, .cpu_reset);

   soc_top i_soc_top (
      .clk100mhz, .cpu_reset, .link_word, .link_word_new, .reply_taken, .reply_word,
      .reply_valid, .bus_rd, .bus_wr, .bus_addr, .bus_wdata, .bus_rdata, .bus_rdata_ready,
      .bus_wr_ack, .irq_ack, .irq_busy, .irq, .irq_num, .cpu_stall, .cpu_restart, .led
   );

   a_reset_state: assert property (@(posedge clk100mhz)
      $rose(cpu_reset) |-> {reply_valid, irq, bus_rdata_ready, led, cpu_stall} == 6'b000001)
      else begin
         errors++;
         $display("mismatch at %0t: %s expected %b got %b", $time,
                  "{reply_valid,irq,bus_rdata_ready,led,cpu_stall}", 6'b000001,
                  $sampled({reply_valid, irq, bus_rdata_ready, led, cpu_stall}));
      end

   a_reply_word: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      $rose(reply_valid) |-> reply_word == exp_reply)
      else begin
         errors++;
         $display("mismatch at %0t: reply_word expected %h got %h",
                  $time, $sampled(exp_reply), $sampled(reply_word));
      end

   a_boot_latency: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      link_word_new && boot_data |-> ##4 reply_valid)
      else begin
         errors++;
         $display("at %0t: read-back reply to a boot word did not arrive in time", $time);
      end

   a_boot_end: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      $rose(reply_valid) && last_word |-> {cpu_restart, cpu_stall, led} == 4'b1011)
      else begin
         errors++;
         $display("mismatch at %0t: {cpu_restart,cpu_stall,led} expected %b got %b",
                  $time, 4'b1011, $sampled({cpu_restart, cpu_stall, led}));
      end

   a_restart_pulse: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      cpu_restart |=> !cpu_restart)
      else begin
         errors++;
         $display("at %0t: cpu_restart stayed high for more than one cycle", $time);
      end

   a_restart_cmd: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      link_word_new && is_cmd && link_word.cmd.code == CMD_RESTART |=> cpu_restart)
      else begin
         errors++;
         $display("at %0t: restart command gave no cpu_restart pulse", $time);
      end

   a_reply_release: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      reply_valid && reply_taken |=> !reply_valid)
      else begin
         errors++;
         $display("at %0t: reply_valid did not fall after reply_taken", $time);
      end

   a_bus_rdata: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      $rose(bus_rdata_ready) |-> bus_rdata == exp_rdata)
      else begin
         errors++;
         $display("mismatch at %0t: bus_rdata expected %h got %h",
                  $time, $sampled(exp_rdata), $sampled(bus_rdata));
      end

   a_ready_release: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      (bus_rdata_ready && !bus_rd) || (bus_wr_ack && !bus_wr)
         |=> !bus_rdata_ready && !bus_wr_ack)
      else begin
         errors++;
         $display("at %0t: bus ready or ack held after the strobe fell", $time);
      end

   a_irq_num: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      $rose(irq) |-> irq_num == exp_irq_num)
      else begin
         errors++;
         $display("mismatch at %0t: irq_num expected %0d got %0d",
                  $time, $sampled(exp_irq_num), $sampled(irq_num));
      end

   task automatic next_cycle();
      @(posedge clk100mhz);
      #1;
   endtask

   task automatic send_word(input word_t w, input logic cmd);
      link_word     = w;
      is_cmd        = cmd;
      link_word_new = 1'b1;
      next_cycle();
      link_word_new = 1'b0;
      is_cmd        = 1'b0;
   endtask

   task automatic take_reply();
      while (!reply_valid)
         next_cycle();
      replies++;
      reply_taken = 1'b1;
      next_cycle();
      reply_taken = 1'b0;
      next_cycle();
   endtask

   task automatic read_bus(input word_t addr, input word_t expected);
      exp_rdata = expected;
      bus_addr  = addr;
      bus_rd    = 1'b1;
      while (!bus_rdata_ready)
         next_cycle();
      bus_rd = 1'b0;
      while (bus_rdata_ready)
         next_cycle();
      reads++;
   endtask

   task automatic write_bus(input word_t addr, input word_t data);
      bus_addr  = addr;
      bus_wdata = data;
      bus_wr    = 1'b1;
      while (!bus_wr_ack)
         next_cycle();
      bus_wr = 1'b0;
      while (bus_wr_ack)
         next_cycle();
   endtask

   task automatic ack_irq();
      while (!irq)
         next_cycle();
      irq_ack = 1'b1;
      next_cycle();
      irq_ack = 1'b0;
      next_cycle();
   endtask

   task automatic boot_image(input int n);
      word_t w;
      send_word({16'h0000, CMD_BOOTLOAD}, 1'b1);
      send_word(word_t'(n), 1'b0);               // word count
      for (int i = 0; i < n; i++) begin
         w = $random(seed);
         boot_words.push_back(w);
         exp_reply = w;                          // read-back echoes the word
         last_word = (i == n - 1);
         boot_data = 1'b1;
         send_word(w, 1'b0);
         boot_data = 1'b0;
         take_reply();
      end
      last_word = 1'b0;
   endtask

   task automatic print_summary();
      $display("summary: %0d errors, %0d replies, %0d bus reads, %0d cycles",
               errors, replies, reads, cycles);
   endtask

   always @(posedge clk100mhz) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         errors++;
         print_summary();
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      word_t w;
      link_word     = '0;
      link_word_new = 1'b0;
      reply_taken   = 1'b0;
      bus_rd        = 1'b0;
      bus_wr        = 1'b0;
      bus_addr      = '0;
      bus_wdata     = '0;
      irq_ack       = 1'b0;
      irq_busy      = 1'b0;
      exp_reply     = '0;
      exp_rdata     = '0;
      exp_irq_num   = IRQ_MAILBOX;
      is_cmd        = 1'b0;
      boot_data     = 1'b0;
      last_word     = 1'b0;
      errors        = 0;
      replies       = 0;
      reads         = 0;
      cycles        = 0;

      wait (cpu_reset);
      next_cycle();

      boot_image(BOOT_WORDS);
      for (int k = 0; k < BOOT_WORDS; k++)
         read_bus(MEM_BASE + k, boot_words[k]);

      // debug reads through the link
      for (int k = 3; k < BOOT_WORDS; k += 3) begin
         exp_reply = boot_words[k];
         send_word({16'h0000, CMD_DEBUGMEM}, 1'b1);
         send_word(word_t'(k), 1'b0);
         take_reply();
      end

      send_word({16'h0000, CMD_RESTART}, 1'b1);
      next_cycle();

      // link to processor mailbox
      w = $random(seed);
      in_q.push_back(w);
      exp_irq_num = IRQ_MAILBOX;
      send_word({16'h0000, CMD_SEND}, 1'b1);
      send_word(w, 1'b0);
      while (!irq)
         next_cycle();
      read_bus(REG_IN_STATUS, 32'd1);
      read_bus(REG_IN_DATA, in_q.pop_front());
      ack_irq();

      // processor to link mailbox
      w = $random(seed);
      out_q.push_back(w);
      write_bus(REG_OUT_DATA, w);
      for (int p = 0; p < 2; p++) begin          // second poll finds it empty
         exp_reply = (out_q.size() > 0) ? out_q.pop_front() : EMPTY_REPLY;
         send_word({16'h0000, CMD_POLL}, 1'b1);
         take_reply();
      end

      exp_irq_num = IRQ_TRAP;
      read_bus(32'h0000_0100, 32'd0);           // nothing mapped here
      ack_irq();

      repeat (4) next_cycle();
      print_summary();
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule
